/* scatter_config.svh */
`ifndef SCATTER_CONFIG_SVH
`define SCATTER_CONFIG_SVH

// elements per activation vector
`define SCATTER_VEC_LEN 4

// bits per signed element
`define SCATTER_PRECISION 8

// outliers that bypass quantization, lowest index first
`define SCATTER_HIGH_SLOTS 2

// magnitude limit, values strictly beyond +/- this are outliers
`define SCATTER_THRESHOLD 40

// low path drops this many lsbs (floor toward minus infinity)
`define SCATTER_LOW_SHIFT 4

// two guard bits cover the sum of four elements
`define SCATTER_SUM_WIDTH (`SCATTER_PRECISION + 2)

`endif

/* scatter_pkg.sv */
`default_nettype none

`include "scatter_config.svh"

package scatter_pkg;

    // one signed activation
    typedef logic signed [`SCATTER_PRECISION-1:0] elem_t;

    // one flag per vector position
    typedef logic [`SCATTER_VEC_LEN-1:0] mask_t;

    // signed accumulation result
    typedef logic signed [`SCATTER_SUM_WIDTH-1:0] sum_t;

    // combiner handshake states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETTLE,
        ST_ACK
    } comb_state_t;

endpackage

`default_nettype wire

/* split_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

interface split_bus_if
    import scatter_pkg::*;
();

    // outliers kept at full precision, zero elsewhere
    elem_t high_vec [`SCATTER_VEC_LEN-1:0];
    // everything else, zero at high slots
    elem_t low_vec [`SCATTER_VEC_LEN-1:0];
    // which positions went to the high side
    mask_t high_mask;

    modport src (output high_vec, output low_vec, output high_mask);

    modport hp_sink (input high_vec);

    modport lp_sink (input low_vec);

endinterface

`default_nettype wire

/* outlier_slot_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module outlier_slot_encoder
    import scatter_pkg::*;
(
    input  mask_t req_vec,
    output mask_t slot_mask
);

    // running count of granted slots, wide enough for a full vector
    logic [$clog2(`SCATTER_VEC_LEN+1)-1:0] taken;

    // scan from index 0 up, grant until the slots run out
    always_comb begin
        slot_mask = '0;
        taken     = '0;
        for (int i = 0; i < `SCATTER_VEC_LEN; i++) begin
            if (req_vec[i] && (taken < `SCATTER_HIGH_SLOTS)) begin
                slot_mask[i] = 1'b1;
                taken        = taken + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* scatter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module scatter
    import scatter_pkg::*;
(
    input  elem_t           data_in [`SCATTER_VEC_LEN-1:0],
    split_bus_if.src        bus
);

    // raw outlier flags, before slot limiting
    mask_t outlier_req;
    // flags that actually won a high slot
    mask_t slot_mask;

    for (genvar i = 0; i < `SCATTER_VEC_LEN; i++) begin : g_flag
        // signed compare, exactly +/- threshold is not an outlier
        assign outlier_req[i] = (data_in[i] > `SCATTER_THRESHOLD) ||
                                (data_in[i] < -`SCATTER_THRESHOLD);
    end

    // lowest index outliers win
    outlier_slot_encoder u_slot_enc (
        .req_vec   (outlier_req),
        .slot_mask (slot_mask)
    );

    // zero-mask split into two complementary vectors
    for (genvar i = 0; i < `SCATTER_VEC_LEN; i++) begin : g_split
        // kept outlier goes high
        assign bus.high_vec[i] = slot_mask[i] ? data_in[i] : '0;
        // everything else goes low
        assign bus.low_vec[i]  = slot_mask[i] ? '0 : data_in[i];
    end

    // mask travels with the vectors to the combiner
    assign bus.high_mask = slot_mask;

endmodule

`default_nettype wire

/* high_precision_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module high_precision_path
    import scatter_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    split_bus_if.hp_sink    bus,
    output sum_t            high_sum
);

    // combinational adder tree of the kept outliers
    sum_t high_total;

    always_comb begin
        high_total = '0;
        for (int i = 0; i < `SCATTER_VEC_LEN; i++) begin
            // signed cast sign-extends to sum width
            high_total = high_total + sum_t'(bus.high_vec[i]);
        end
    end

    // one-stage pipeline, captures every edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            high_sum <= '0;
        end else begin
            high_sum <= high_total;
        end
    end

endmodule

`default_nettype wire

/* low_precision_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module low_precision_path
    import scatter_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    split_bus_if.lp_sink    bus,
    output sum_t            low_sum
);

    // coarse-grid copies of the low elements
    elem_t quant_vec [`SCATTER_VEC_LEN-1:0];
    sum_t  low_total;

    for (genvar i = 0; i < `SCATTER_VEC_LEN; i++) begin : g_quant
        // arithmetic shift down then back up, floors toward minus infinity
        assign quant_vec[i] =
            elem_t'((bus.low_vec[i] >>> `SCATTER_LOW_SHIFT) <<< `SCATTER_LOW_SHIFT);
    end

    always_comb begin
        low_total = '0;
        for (int i = 0; i < `SCATTER_VEC_LEN; i++) begin
            // sign-extend each quantized element before adding
            low_total = low_total + sum_t'(quant_vec[i]);
        end
    end

    // register every cycle, same latency as the high path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_sum <= '0;
        end else begin
            low_sum <= low_total;
        end
    end

endmodule

`default_nettype wire

/* mixed_sum_combiner.sv */
`timescale 1ns/1ps
`default_nettype none

module mixed_sum_combiner
    import scatter_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  sum_t  high_sum,
    input  sum_t  low_sum,
    input  mask_t mask_in,
    output logic  ack,
    output sum_t  sum,
    output mask_t outlier_mask
);

    comb_state_t state;
    comb_state_t state_next;

    // four-phase handshake sequencing
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // paths capture the stable data on this same edge
                if (req) begin
                    state_next = ST_SETTLE;
                end
            end
            // one cycle for the path registers to hold valid sums
            ST_SETTLE: state_next = ST_ACK;
            ST_ACK: begin
                // wait for the producer to drop req
                if (!req) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            sum          <= '0;
            outlier_mask <= '0;
        end else begin
            state <= state_next;
            // capture on leaving settle, held through ack
            if (state == ST_SETTLE) begin
                sum          <= high_sum + low_sum;
                outlier_mask <= mask_in;
            end
        end
    end

    // ack straight from state, high for the whole ack phase
    assign ack = (state == ST_ACK);

endmodule

`default_nettype wire

/* outlier_quant_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module outlier_quant_top
    import scatter_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  elem_t data_in [`SCATTER_VEC_LEN-1:0],
    output logic  ack,
    output sum_t  sum,
    output mask_t outlier_mask
);

    // split vectors between scatter and the two paths
    split_bus_if bus ();

    // registered partial sums
    sum_t high_sum;
    sum_t low_sum;

    scatter u_scatter (
        .data_in (data_in),
        .bus     (bus.src)
    );

    // full-precision side
    high_precision_path u_hp (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.hp_sink),
        .high_sum (high_sum)
    );

    // quantized side
    low_precision_path u_lp (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus.lp_sink),
        .low_sum (low_sum)
    );

    // mask taken straight off the bus, stable while req is high
    mixed_sum_combiner u_comb (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .high_sum     (high_sum),
        .low_sum      (low_sum),
        .mask_in      (bus.high_mask),
        .ack          (ack),
        .sum          (sum),
        .outlier_mask (outlier_mask)
    );

endmodule

`default_nettype wire

/* scatter_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module scatter_checker
    import scatter_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  req,
    input logic  ack,
    input mask_t outlier_mask
);

    // req seen at edge N, ack sampled low at N+1, high at N+2
    property ack_rise_latency;
        @(posedge clk) disable iff (!rst_n)
            $rose(req) |-> !ack ##1 !ack ##1 ack;
    endproperty

    // ack drops on the edge that sees req low
    property ack_fall_latency;
        @(posedge clk) disable iff (!rst_n)
            $fell(req) |-> ack ##1 !ack;
    endproperty

    // never more kept outliers than slots
    property mask_slot_limit;
        @(posedge clk) disable iff (!rst_n)
            $countones(outlier_mask) <= `SCATTER_HIGH_SLOTS;
    endproperty

    a_ack_rise: assert property (ack_rise_latency)
        else $error("ack did not rise two cycles after req");

    a_ack_fall: assert property (ack_fall_latency)
        else $error("ack did not fall one cycle after req");

    a_mask_limit: assert property (mask_slot_limit)
        else $error("outlier_mask has more bits than high slots");

endmodule

`default_nettype wire

/* scoreboard_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module scoreboard_monitor
    import scatter_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  elem_t data_in [`SCATTER_VEC_LEN-1:0],
    input  logic  ack,
    input  sum_t  sum,
    input  mask_t outlier_mask,
    output int    test_count,
    output int    error_count
);

    logic req_q;
    logic ack_q;
    int   cycle;
    int   req_rise_cycle;
    int   req_fall_cycle;

    // model from the outlier rules, sum kept as a full int
    task automatic build_expected(output mask_t m, output int total);
        int kept;
        int v;
        kept  = 0;
        total = 0;
        m     = '0;
        for (int i = 0; i < `SCATTER_VEC_LEN; i++) begin
            v = int'(data_in[i]);
            if ((v > `SCATTER_THRESHOLD || v < -`SCATTER_THRESHOLD) &&
                kept < `SCATTER_HIGH_SLOTS) begin
                m[i]  = 1'b1;
                kept  = kept + 1;
                total = total + v;
            end else begin
                // clearing low bits of a two's complement value floors it
                total = total + (v - (v & ((1 << `SCATTER_LOW_SHIFT) - 1)));
            end
        end
    endtask

    task automatic check_result();
        mask_t exp_mask;
        int    exp_total;
        int    errs_before;
        errs_before = error_count;
        build_expected(exp_mask, exp_total);
        if (outlier_mask !== exp_mask) begin
            $display("ERR %0t outlier_mask expected %b actual %b",
                     $time, exp_mask, outlier_mask);
            error_count = error_count + 1;
        end
        // int compare also catches a sum that wrapped
        if ($isunknown(sum) || int'(sum) != exp_total) begin
            $display("ERR %0t sum expected %0d actual %0d", $time, exp_total, sum);
            error_count = error_count + 1;
        end
        if (cycle - req_rise_cycle != 2) begin
            $display("ack rose %0d cycles after req instead of 2", cycle - req_rise_cycle);
            error_count = error_count + 1;
        end
        $display("test %0d data %0d %0d %0d %0d mask %b sum %0d %s", test_count,
                 data_in[0], data_in[1], data_in[2], data_in[3], outlier_mask, sum,
                 (error_count == errs_before) ? "ok" : "FAILED");
        test_count = test_count + 1;
    endtask

    initial begin
        test_count     = 0;
        error_count    = 0;
        cycle          = 0;
        req_rise_cycle = 0;
        req_fall_cycle = 0;
        req_q          = 1'b0;
        ack_q          = 1'b0;
    end

    // values sampled here were set on the previous edge or the last negedge
    always @(posedge clk) begin
        if (rst_n) begin
            if (req && !req_q) begin
                req_rise_cycle = cycle;
            end
            if (!req && req_q) begin
                req_fall_cycle = cycle;
            end
            if (ack && !ack_q) begin
                check_result();
            end
            if (!ack && ack_q && (cycle - req_fall_cycle != 1)) begin
                $display("ack fell %0d cycles after req instead of 1",
                         cycle - req_fall_cycle);
                error_count = error_count + 1;
            end
            req_q = req;
            ack_q = ack;
            cycle = cycle + 1;
        end
    end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scatter_config.svh"

module tb_top
    import scatter_pkg::*;
();

    localparam int NUM_VECS     = 24;
    localparam int NUM_FIXED    = 10;
    localparam int RESET_CYCLES = 3;

    logic   clk;
    logic   rst_n;
    logic   req;
    logic   ack;
    elem_t  data_in [`SCATTER_VEC_LEN-1:0];
    sum_t   sum;
    mask_t  outlier_mask;
    integer seed;
    int     test_count;
    int     error_count;
    int     tb_errors;

    // stimulus only, expected values come from the monitor model
    elem_t stim [NUM_VECS][`SCATTER_VEC_LEN];

    outlier_quant_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .data_in      (data_in),
        .ack          (ack),
        .sum          (sum),
        .outlier_mask (outlier_mask)
    );

    scoreboard_monitor u_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .data_in      (data_in),
        .ack          (ack),
        .sum          (sum),
        .outlier_mask (outlier_mask),
        .test_count   (test_count),
        .error_count  (error_count)
    );

    // handshake and mask assertions on the combiner
    bind mixed_sum_combiner scatter_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .ack          (ack),
        .outlier_mask (outlier_mask)
    );

    task automatic set_entry(input int idx, input int e0, input int e1,
                             input int e2, input int e3);
        stim[idx][0] = elem_t'(e0);
        stim[idx][1] = elem_t'(e1);
        stim[idx][2] = elem_t'(e2);
        stim[idx][3] = elem_t'(e3);
    endtask

    task automatic fill_table();
        // no outliers, 40 and -40 sit exactly on the threshold
        set_entry(0, 5, -7, 17, 40);
        set_entry(1, 0, -1, -40, 31);
        // one and two outliers
        set_entry(2, 41, 3, -20, 9);
        set_entry(3, -41, 10, 100, -3);
        set_entry(4, 40, -40, 41, -41);
        // three and four outliers, only the lowest two kept
        set_entry(5, 50, -60, 70, 1);
        set_entry(6, 127, -128, 90, -90);
        // extremes reach the ends of the sum range
        set_entry(7, -128, -128, -128, -128);
        set_entry(8, 127, 127, 127, 127);
        set_entry(9, -128, 127, -128, 127);
        for (int i = NUM_FIXED; i < NUM_VECS; i++) begin
            for (int j = 0; j < `SCATTER_VEC_LEN; j++) begin
                stim[i][j] = elem_t'($random(seed));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // worst case per handshake is well under 20 cycles
    initial begin
        repeat (NUM_VECS * 20 + RESET_CYCLES) @(posedge clk);
        $display("timeout, a handshake did not complete in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed      = 32'hb3473969;
        rst_n     = 1'b0;
        req       = 1'b0;
        tb_errors = 0;
        for (int j = 0; j < `SCATTER_VEC_LEN; j++) begin
            data_in[j] = '0;
        end
        fill_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (ack !== 1'b0) begin
            $display("ERR %0t ack expected 0 actual %b", $time, ack);
            tb_errors = tb_errors + 1;
        end
        // four-phase loop, next request goes out on the negedge that sees ack low
        for (int t = 0; t < NUM_VECS; t++) begin
            for (int j = 0; j < `SCATTER_VEC_LEN; j++) begin
                data_in[j] = stim[t][j];
            end
            req = 1'b1;
            while (ack !== 1'b1) @(negedge clk);
            req = 1'b0;
            while (ack !== 1'b0) @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (test_count != NUM_VECS) begin
            $display("got %0d acks for %0d requests", test_count, NUM_VECS);
            tb_errors = tb_errors + 1;
        end
        $display("tests %0d, errors %0d", test_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
scatter_pkg.sv
split_bus_if.sv
outlier_slot_encoder.sv
scatter.sv
high_precision_path.sv
low_precision_path.sv
mixed_sum_combiner.sv
outlier_quant_top.sv
scatter_checker.sv
scoreboard_monitor.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
